//--- src/zcmp_pkg.sv
package zcmp_pkg;

  //////////////////////////////
  // FIFO sizing
  //////////////////////////////

  // Entries per FIFO, same on input and output side
  localparam int unsigned FIFO_DEPTH = 4;

  // Pointer and occupancy widths derived from the depth
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  //////////////////////////////
  // RV32I encodings
  //////////////////////////////

  // Major opcodes used by the expanded sequences
  localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE = 7'b0100011;
  localparam logic [6:0] OPCODE_OPIMM = 7'b0010011;
  localparam logic [6:0] OPCODE_JALR  = 7'b1100111;

  // Architectural register numbers
  localparam logic [4:0] REG_RA = 5'd1;
  localparam logic [4:0] REG_SP = 5'd2;
  localparam logic [4:0] REG_A0 = 5'd10;
  localparam logic [4:0] REG_A1 = 5'd11;

  //////////////////////////////
  // Types
  //////////////////////////////

  // Compressed word as fetched
  typedef logic [15:0] cinstr_t;

  // Expanded word as handed to decode
  typedef logic [31:0] rinstr_t;

  // Kind of the word at the head of the input FIFO
  typedef enum logic [2:0] {
    INVALID_INST,
    PUSH,
    POP,
    POPRET,
    POPRETZ,
    MVSA01,
    MVA01S
  } seq_instr_e;

  // Sequencer state
  // S_IDLE also emits the first half of a double move
  typedef enum logic [2:0] {
    S_IDLE,
    S_SREG,
    S_RA,
    S_SP,
    S_A0,
    S_RET,
    S_DMOVE
  } seq_state_e;

  //////////////////////////////
  // Helper functions
  //////////////////////////////

  // Number of s-registers saved for a given rlist
  // rlist 4 is ra only, 5 adds s0 and so on
  // rlist 15 covers s0 to s11, there is no encoding for s0 to s10
  // Values below 4 are reserved and give zero
  function automatic logic [3:0] pushpop_reg_length(input logic [3:0] rlist);
    logic [3:0] len;
    if (rlist == 4'd15) begin
      len = 4'd12;
    end else if (rlist >= 4'd4) begin
      len = rlist - 4'd4;
    end else begin
      len = 4'd0;
    end
    return len;
  endfunction

  // Map s-register index to its x-register number
  // s0 and s1 sit at x8 and x9
  // s2 up to s11 sit at x18 up to x27
  function automatic logic [4:0] sn_to_regnum(input logic [3:0] sn);
    logic [4:0] regnum;
    if (sn < 4'd2) begin
      regnum = 5'd8 + 5'(sn);
    end else begin
      regnum = 5'd16 + 5'(sn);
    end
    return regnum;
  endfunction

  // Round a byte count up to the next multiple of 16
  // Stack frames stay 16-byte aligned per the calling convention
  function automatic logic [11:0] align_16(input logic [11:0] bytes);
    logic [11:0] rounded;
    rounded = (bytes + 12'd15) & ~12'd15;
    return rounded;
  endfunction

endpackage

//--- src/seq_fifo.sv
`timescale 1ns/1ps

module seq_fifo
  import zcmp_pkg::*;
#(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,
  input  logic push_valid_i,
  input  T     push_data_i,
  output logic push_ready_o,
  output logic pop_valid_o,
  output T     pop_data_o,
  input  logic pop_ready_i
);

  // Circular storage
  T mem [FIFO_DEPTH];

  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] cnt_q;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  assign full        = (cnt_q == FIFO_CNT_W'(FIFO_DEPTH));
  assign pop_valid_o = (cnt_q != '0);
  assign pop_data_o  = mem[rd_ptr_q];

  // Room when not full, or when the head leaves this cycle
  assign push_ready_o = !full || pop_ready_i;

  assign do_push = push_valid_i && push_ready_o;
  assign do_pop  = pop_valid_o && pop_ready_i;

  // Payload write, visible at the head one cycle later
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap at the last entry
  // Occupancy tracks push minus pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        // Both or neither, level unchanged
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

//--- src/pushpop_sequencer.sv
`timescale 1ns/1ps

module pushpop_sequencer
  import zcmp_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  cinstr_t instr_i,
  input  logic    valid_i,
  input  logic    ready_i,
  output rinstr_t instr_o,
  output logic    valid_o,
  output logic    ready_o,
  output logic    seq_last_o,
  output logic    reject_o
);

  // Decoded kind of the head word
  seq_instr_e  seq_instr;

  // FSM
  seq_state_e  state_q;
  seq_state_e  state_n;
  seq_state_e  cur_state;

  // Emitted-instruction count within the current sequence
  logic [3:0]  cnt_q;

  // Fields of the compressed word
  logic [3:0]  rlist;
  logic [1:0]  spimm;
  logic        rlist_ok;

  // Stack frame arithmetic
  logic [3:0]  regs_saved;
  logic [3:0]  sreg;
  logic [11:0] reg_stack_adj;
  logic [11:0] total_stack_adj;
  logic [11:0] sp_adj;
  logic [11:0] cnt_bytes;
  logic [11:0] cur_offset;

  // Helpers
  logic        is_load;
  logic        is_move;
  logic        accept;

  assign rlist    = instr_i[7:4];
  assign spimm    = instr_i[3:2];
  assign rlist_ok = (rlist >= 4'd4);

  //////////////////////////////
  // Decode
  //////////////////////////////

  // Everything sits in quadrant C2 with funct3 101
  always_comb begin
    seq_instr = INVALID_INST;
    if ((instr_i[1:0] == 2'b10) && (instr_i[15:13] == 3'b101)) begin
      case (instr_i[12:10])
        3'b011: begin
          // Double moves are told apart by bits 6:5
          if (instr_i[6:5] == 2'b01) begin
            seq_instr = MVSA01;
          end else if (instr_i[6:5] == 2'b11) begin
            seq_instr = MVA01S;
          end
        end
        3'b110: begin
          // cm.push or cm.pop
          // Reserved rlist stays invalid
          if ((instr_i[9:8] == 2'b00) && rlist_ok) begin
            seq_instr = PUSH;
          end else if ((instr_i[9:8] == 2'b10) && rlist_ok) begin
            seq_instr = POP;
          end
        end
        3'b111: begin
          // cm.popretz or cm.popret
          if ((instr_i[9:8] == 2'b00) && rlist_ok) begin
            seq_instr = POPRETZ;
          end else if ((instr_i[9:8] == 2'b10) && rlist_ok) begin
            seq_instr = POPRET;
          end
        end
        default: begin
          seq_instr = INVALID_INST;
        end
      endcase
    end
  end

  assign is_load = (seq_instr == POP) || (seq_instr == POPRET) || (seq_instr == POPRETZ);
  assign is_move = (seq_instr == MVSA01) || (seq_instr == MVA01S);

  // Handshake
  assign valid_o  = valid_i && (seq_instr != INVALID_INST);
  assign reject_o = valid_i && (seq_instr == INVALID_INST);
  assign accept   = valid_o && ready_i;

  // Head word leaves on the last accepted output or on a reject
  assign ready_o  = reject_o || (accept && seq_last_o);

  //////////////////////////////
  // Stack frame
  //////////////////////////////

  assign regs_saved = pushpop_reg_length(rlist);

  // s-registers plus ra rounded to 16 bytes
  assign reg_stack_adj = align_16((12'(regs_saved) + 12'd1) << 2);

  // Immediate adds whole 16-byte blocks
  assign total_stack_adj = reg_stack_adj + {6'd0, spimm, 4'd0};
  assign sp_adj          = is_load ? total_stack_adj : 12'd0 - total_stack_adj;

  // Byte distance of the current slot from the frame top
  assign cnt_bytes  = (12'(cnt_q) + 12'd1) << 2;
  // Push counts down from sp and pop from the rewound sp
  assign cur_offset = is_load ? total_stack_adj - cnt_bytes : 12'd0 - cnt_bytes;

  // Highest s-register first
  assign sreg = regs_saved - cnt_q - 4'd1;

  //////////////////////////////
  // Sequencing
  //////////////////////////////

  // Push and pop skip straight to S_SREG or S_RA from idle
  // so the first word is emitted without a wasted cycle
  always_comb begin
    cur_state = state_q;
    if ((state_q == S_IDLE) && (seq_instr != INVALID_INST) && !is_move) begin
      cur_state = (regs_saved != 4'd0) ? S_SREG : S_RA;
    end
  end

  // Output word and next state per step
  always_comb begin
    instr_o    = '0;
    state_n    = cur_state;
    seq_last_o = 1'b0;
    case (cur_state)
      S_IDLE: begin
        // First half of a double move
        if (seq_instr == MVSA01) begin
          instr_o = {12'h000, REG_A0, 3'b000, sn_to_regnum({1'b0, instr_i[9:7]}), OPCODE_OPIMM};
        end else if (seq_instr == MVA01S) begin
          instr_o = {12'h000, sn_to_regnum({1'b0, instr_i[9:7]}), 3'b000, REG_A0, OPCODE_OPIMM};
        end
        if (is_move) begin
          state_n = S_DMOVE;
        end
      end
      S_SREG: begin
        // lw or sw of s(sreg) against sp
        if (is_load) begin
          instr_o = {cur_offset, REG_SP, 3'b010, sn_to_regnum(sreg), OPCODE_LOAD};
        end else begin
          instr_o = {cur_offset[11:5], sn_to_regnum(sreg), REG_SP, 3'b010,
                     cur_offset[4:0], OPCODE_STORE};
        end
        if (cnt_q == regs_saved - 4'd1) begin
          state_n = S_RA;
        end
      end
      S_RA: begin
        // ra goes below the s-registers
        if (is_load) begin
          instr_o = {cur_offset, REG_SP, 3'b010, REG_RA, OPCODE_LOAD};
        end else begin
          instr_o = {cur_offset[11:5], REG_RA, REG_SP, 3'b010, cur_offset[4:0], OPCODE_STORE};
        end
        state_n = S_SP;
      end
      S_SP: begin
        // addi sp, sp, +/-total
        instr_o = {sp_adj, REG_SP, 3'b000, REG_SP, OPCODE_OPIMM};
        if (seq_instr == POPRETZ) begin
          state_n = S_A0;
        end else if (seq_instr == POPRET) begin
          state_n = S_RET;
        end else begin
          state_n    = S_IDLE;
          seq_last_o = 1'b1;
        end
      end
      S_A0: begin
        // addi a0, x0, 0
        instr_o = {12'h000, 5'd0, 3'b000, REG_A0, OPCODE_OPIMM};
        state_n = S_RET;
      end
      S_RET: begin
        // jalr x0, 0(ra)
        instr_o    = {12'h000, REG_RA, 3'b000, 5'd0, OPCODE_JALR};
        state_n    = S_IDLE;
        seq_last_o = 1'b1;
      end
      S_DMOVE: begin
        // Second half of a double move uses a1 and r2
        if (seq_instr == MVSA01) begin
          instr_o = {12'h000, REG_A1, 3'b000, sn_to_regnum({1'b0, instr_i[4:2]}), OPCODE_OPIMM};
        end else begin
          instr_o = {12'h000, sn_to_regnum({1'b0, instr_i[4:2]}), 3'b000, REG_A1, OPCODE_OPIMM};
        end
        state_n    = S_IDLE;
        seq_last_o = 1'b1;
      end
      default: begin
        state_n = S_IDLE;
      end
    endcase
  end

  // State and count move only on an accepted output
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end else if (accept) begin
      state_q <= state_n;
      if (seq_last_o) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 4'd1;
      end
    end
  end

endmodule

//--- src/zcmp_expander_top.sv
`timescale 1ns/1ps

module zcmp_expander_top
  import zcmp_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid_i,
  input  cinstr_t in_instr_i,
  output logic    in_ready_o,
  output logic    out_valid_o,
  output rinstr_t out_instr_o,
  input  logic    out_ready_i,
  output logic    reject_o
);

  // Input FIFO head towards the sequencer
  logic    head_valid;
  cinstr_t head_instr;
  logic    head_pop;

  // Sequencer output towards the output FIFO
  logic    seq_valid;
  rinstr_t seq_instr;
  logic    seq_ready;

  // Compressed words from fetch
  seq_fifo #(
    .T (cinstr_t)
  ) u_in_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid_i (in_valid_i),
    .push_data_i  (in_instr_i),
    .push_ready_o (in_ready_o),
    .pop_valid_o  (head_valid),
    .pop_data_o   (head_instr),
    .pop_ready_i  (head_pop)
  );

  // Expansion of the head word
  pushpop_sequencer u_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr_i    (head_instr),
    .valid_i    (head_valid),
    .ready_i    (seq_ready),
    .instr_o    (seq_instr),
    .valid_o    (seq_valid),
    .ready_o    (head_pop),
    .seq_last_o (),
    .reject_o   (reject_o)
  );

  // Expanded words towards decode
  seq_fifo #(
    .T (rinstr_t)
  ) u_out_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid_i (seq_valid),
    .push_data_i  (seq_instr),
    .push_ready_o (seq_ready),
    .pop_valid_o  (out_valid_o),
    .pop_data_o   (out_instr_o),
    .pop_ready_i  (out_ready_i)
  );

endmodule

//--- verification/tb_zcmp_checker.sv
`timescale 1ns/1ps

module tb_zcmp_checker
  import zcmp_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid_i,
  input  cinstr_t in_instr_i,
  input  logic    in_ready_i,
  input  logic    out_valid_i,
  input  rinstr_t out_instr_i,
  input  logic    out_ready_i,
  input  logic    reject_i,
  input  logic    end_i,
  output logic    idle_o,
  output logic    done_o,
  output int      err_cnt_o
);

  // Expected expansion, one entry per instruction
  rinstr_t exp_instr_q[$];
  bit      exp_last_q[$];
  // Expected rejects, tagged with the instruction count ahead of them
  int      rej_cum_q[$];

  int      instr_pushed = 0;
  int      outs_seen    = 0;
  int      words_in     = 0;
  int      words_done   = 0;
  int      rejects_seen = 0;
  int      err_cnt      = 0;
  rinstr_t exp_instr;
  bit      exp_last;
  int      pending;

  assign err_cnt_o = err_cnt;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // s-register index to x-register
  function automatic logic [4:0] s_reg_x(input int k);
    return (k < 2) ? 5'(8 + k) : 5'(18 + (k - 2));
  endfunction

  function automatic rinstr_t i_type(input int imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
    logic [11:0] imm12;
    imm12 = imm[11:0];
    return {imm12, rs1, f3, rd, op};
  endfunction

  // sw rs2, imm(rs1)
  function automatic rinstr_t s_type(input int imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1);
    logic [11:0] imm12;
    imm12 = imm[11:0];
    return {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], OPCODE_STORE};
  endfunction

  task automatic add_instr(input rinstr_t ins, input bit last);
    exp_instr_q.push_back(ins);
    exp_last_q.push_back(last);
    instr_pushed++;
  endtask

  // Expected result of one accepted compressed word
  task automatic expect_word(input cinstr_t w);
    int n;
    int frame;
    int k;
    bit c2_101;
    bit is_push;
    c2_101 = (w[1:0] == 2'b10) && (w[15:13] == 3'b101);
    n      = (w[7:4] == 4'd15) ? 12 : int'(w[7:4]) - 4;
    // Frame is s-regs plus ra rounded to 16, then 16 per spimm step
    frame  = ((4 * (n + 1) + 15) / 16) * 16 + 16 * int'(w[3:2]);
    if (c2_101 && (w[12:10] == 3'b011) && (w[6:5] == 2'b01)) begin
      // cm.mvsa01
      add_instr(i_type(0, REG_A0, 3'b000, s_reg_x(int'(w[9:7])), OPCODE_OPIMM), 1'b0);
      add_instr(i_type(0, REG_A1, 3'b000, s_reg_x(int'(w[4:2])), OPCODE_OPIMM), 1'b1);
    end else if (c2_101 && (w[12:10] == 3'b011) && (w[6:5] == 2'b11)) begin
      // cm.mva01s
      add_instr(i_type(0, s_reg_x(int'(w[9:7])), 3'b000, REG_A0, OPCODE_OPIMM), 1'b0);
      add_instr(i_type(0, s_reg_x(int'(w[4:2])), 3'b000, REG_A1, OPCODE_OPIMM), 1'b1);
    end else if (c2_101 && (w[12:11] == 2'b11) && !w[8] && (w[7:4] >= 4'd4)) begin
      // w[10:9] selects push, pop, popretz, popret
      is_push = (w[10:9] == 2'b00);
      for (k = 0; k < n; k++) begin
        if (is_push) begin
          add_instr(s_type(-4 * (k + 1), s_reg_x(n - 1 - k), REG_SP), 1'b0);
        end else begin
          add_instr(i_type(frame - 4 * (k + 1), REG_SP, 3'b010, s_reg_x(n - 1 - k),
                           OPCODE_LOAD), 1'b0);
        end
      end
      if (is_push) begin
        add_instr(s_type(-4 * (n + 1), REG_RA, REG_SP), 1'b0);
        add_instr(i_type(-frame, REG_SP, 3'b000, REG_SP, OPCODE_OPIMM), 1'b1);
      end else begin
        add_instr(i_type(frame - 4 * (n + 1), REG_SP, 3'b010, REG_RA, OPCODE_LOAD), 1'b0);
        add_instr(i_type(frame, REG_SP, 3'b000, REG_SP, OPCODE_OPIMM), !w[10]);
      end
      if (w[10:9] == 2'b10) begin
        add_instr(i_type(0, 5'd0, 3'b000, REG_A0, OPCODE_OPIMM), 1'b0);
      end
      if (w[10]) begin
        add_instr(i_type(0, REG_RA, 3'b000, 5'd0, OPCODE_JALR), 1'b1);
      end
    end else begin
      rej_cum_q.push_back(instr_pushed);
    end
  endtask

  //////////////////////////////
  // Port monitor
  //////////////////////////////

  // All counters hold their pre-edge values until the input update at the end
  always @(posedge clk) begin
    if (!rst_n) begin
      idle_o = 1'b1;
      done_o = 1'b0;
    end else begin
      // Input may only stall with a full FIFO worth of words in flight
      if (!in_ready_i && (words_in - words_done < FIFO_DEPTH)) begin
        err_cnt++;
        $display("[ERROR] %0t: in_ready_o low with %0d words in flight",
                 $time, words_in - words_done);
      end
      // Reject pulse, all earlier output must already sit in the output FIFO
      if (reject_i) begin
        if (rej_cum_q.size() == 0) begin
          err_cnt++;
          $display("[ERROR] %0t: reject pulse for a word the model expands", $time);
        end else begin
          pending = rej_cum_q.pop_front() - outs_seen;
          if ((pending < 0) || (pending > FIFO_DEPTH)) begin
            err_cnt++;
            $display("[ERROR] %0t: reject out of order, %0d outputs still ahead",
                     $time, pending);
          end
        end
        rejects_seen++;
        words_done++;
      end
      // Output handshake against the next expected instruction
      if (out_valid_i && out_ready_i) begin
        if (exp_instr_q.size() == 0) begin
          err_cnt++;
          $display("[ERROR] %0t: unexpected output %08h", $time, out_instr_i);
        end else begin
          exp_instr = exp_instr_q.pop_front();
          exp_last  = exp_last_q.pop_front();
          if (out_instr_i !== exp_instr) begin
            err_cnt++;
            $display("[ERROR] %0t: output %0d expected %08h got %08h",
                     $time, outs_seen, exp_instr, out_instr_i);
          end
          if (exp_last) begin
            words_done++;
          end
        end
        outs_seen++;
      end
      // New word into the model
      if (in_valid_i && in_ready_i) begin
        expect_word(in_instr_i);
        words_in++;
      end
      idle_o = (exp_instr_q.size() == 0) && (rej_cum_q.size() == 0);
      // Closing report, leftovers count as one error
      if (end_i && !done_o) begin
        if (!idle_o) begin
          err_cnt++;
          $display("Run ended with %0d expected instructions and %0d rejects missing",
                   exp_instr_q.size(), rej_cum_q.size());
        end
        $display("Checker: %0d words, %0d instructions, %0d rejects, %0d errors",
                 words_in, outs_seen, rejects_seen, err_cnt);
        done_o = 1'b1;
      end
    end
  end

endmodule

//--- verification/tb_zcmp.sv
`timescale 1ns/1ps

module tb_zcmp
  import zcmp_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int NUM_WORDS  = 400;
  // Generous per-word budget, longest expansion is 16 instructions
  localparam int TIMEOUT_NS = NUM_WORDS * 16 * CLK_PERIOD;

  logic    clk;
  logic    rst_n;
  logic    in_valid_i;
  cinstr_t in_instr_i;
  logic    in_ready_o;
  logic    out_valid_o;
  rinstr_t out_instr_o;
  logic    out_ready_i;
  logic    reject_o;

  // Checker control
  logic    end_check;
  logic    check_idle;
  logic    check_done;
  int      err_cnt;

  integer  seed = 32'ha79a5601;
  integer  bp_seed;

  zcmp_expander_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_instr_i  (in_instr_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_instr_o (out_instr_o),
    .out_ready_i (out_ready_i),
    .reject_o    (reject_o)
  );

  tb_zcmp_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_instr_i  (in_instr_i),
    .in_ready_i  (in_ready_o),
    .out_valid_i (out_valid_o),
    .out_instr_i (out_instr_o),
    .out_ready_i (out_ready_i),
    .reject_i    (reject_o),
    .end_i       (end_check),
    .idle_o      (check_idle),
    .done_o      (check_done),
    .err_cnt_o   (err_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // 70 % Zcmp, 10 % push/pop with reserved rlist, rest raw random
  task automatic make_word(output cinstr_t w);
    int         pick;
    int         kind;
    logic [3:0] rlist;
    logic [1:0] spimm;
    logic [2:0] r1;
    logic [2:0] r2;
    pick  = {$random(seed)} % 10;
    kind  = {$random(seed)} % 6;
    rlist = 4'(4 + {$random(seed)} % 12);
    spimm = 2'($random(seed));
    r1    = 3'($random(seed));
    r2    = 3'($random(seed));
    if (pick == 7) begin
      rlist = 4'($random(seed) & 3);
      kind  = {$random(seed)} % 4;
    end
    case (kind)
      0:       w = {3'b101, 5'b11000, rlist, spimm, 2'b10};
      1:       w = {3'b101, 5'b11010, rlist, spimm, 2'b10};
      2:       w = {3'b101, 5'b11100, rlist, spimm, 2'b10};
      3:       w = {3'b101, 5'b11110, rlist, spimm, 2'b10};
      4:       w = {3'b101, 3'b011, r1, 2'b01, r2, 2'b10};
      default: w = {3'b101, 3'b011, r1, 2'b11, r2, 2'b10};
    endcase
    if (pick >= 8) begin
      w = 16'($random(seed));
    end
  endtask

  // Hold the word until the handshake edge, ready sampled at the falling edge
  task automatic offer_word(input cinstr_t w);
    in_valid_i <= 1'b1;
    in_instr_i <= w;
    @(negedge clk);
    while (!in_ready_o) @(negedge clk);
    @(posedge clk);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    cinstr_t word;
    int      i;
    rst_n      = 1'b0;
    in_valid_i = 1'b0;
    in_instr_i = '0;
    end_check  = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (i = 0; i < NUM_WORDS; i++) begin
      // Occasional idle cycle on the input
      if ({$random(seed)} % 8 == 0) begin
        in_valid_i <= 1'b0;
        @(posedge clk);
      end
      make_word(word);
      offer_word(word);
    end
    in_valid_i <= 1'b0;
    // Wait until the model has seen everything it expects
    @(negedge clk);
    while (!check_idle) @(negedge clk);
    // Margin for stray output
    repeat (8) @(posedge clk);
    end_check <= 1'b1;
    @(negedge clk);
    while (!check_done) @(negedge clk);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Random back-pressure, ready on about 70 % of cycles
  initial begin
    bp_seed     = seed ^ 32'h0000ffff;
    out_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      out_ready_i <= ({$random(bp_seed)} % 10) >= 3;
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout, the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- flist.f
src/zcmp_pkg.sv
src/seq_fifo.sv
src/pushpop_sequencer.sv
src/zcmp_expander_top.sv
verification/tb_zcmp_checker.sv
verification/tb_zcmp.sv

//--- Makefile
# Verilator build and run of the Zcmp expander testbench

VERILATOR := verilator
VFLAGS    := --binary --timing -j 0 -Wno-fatal
TOP       := tb_zcmp
FLIST     := flist.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)

check: run
	@grep -q "^Finished with no errors$$" $(SIM_LOG) || \
		(echo "Simulation failed, see $(SIM_LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)
